//--- compile.f
source/frontendPkg.sv
source/frontendIfc.sv
source/cmdIntake.sv
source/posMap.sv
source/uoramController.sv
source/integrityVerifier.sv
source/frontend.sv
tb/frontend_sva.sv
tb/frontendTb.sv

//--- run.sh
#!/bin/sh
# Build the frontend testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f compile.f --top-module frontendTb -o frontendSim &&
./obj_dir/frontendSim | tee /dev/stderr | grep -q "^=== PASS ===$" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

//--- source/cmdIntake.sv
/* Holds one request. Write data is only taken after its write command,
   so a data beat sent early waits on a low dataInReady. */

`timescale 1ns/1ps

module cmdIntake (
    input  logic                              Clock,
    input  logic                              reset,
    input  logic                              cmdInValid,
    output logic                              cmdInReady,
    input  frontendPkg::cmdT                  cmdIn,
    input  logic [frontendPkg::addrWidth-1:0] progAddrIn,
    input  logic                              dataInValid,
    output logic                              dataInReady,
    input  frontendPkg::dataT                 dataIn,
    streamIf.source                           req
);

    logic             pendingWrite;
    logic             reqValid;
    frontendPkg::reqT reqReg;
    logic             cmdFire;
    logic             dataFire;

    assign cmdFire  = cmdInValid && cmdInReady;
    assign dataFire = dataInValid && dataInReady;

    // Both inputs stall while a request is held
    assign cmdInReady  = !pendingWrite && !reqValid;
    assign dataInReady = pendingWrite && !reqValid;

    always_ff @(posedge Clock) begin
        if (reset) begin
            pendingWrite <= 1'b0;
            reqValid     <= 1'b0;
        end else begin
            if (cmdFire) begin
                if (cmdIn == frontendPkg::cmdWrite) begin
                    pendingWrite <= 1'b1;
                end else begin
                    reqValid <= 1'b1;
                end
            end
            if (dataFire) begin
                pendingWrite <= 1'b0;
                reqValid     <= 1'b1;
            end
            if (req.valid && req.ready) begin
                reqValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (cmdFire) begin
            reqReg.cmd  <= cmdIn;
            reqReg.addr <= progAddrIn;
            reqReg.data <= '0;
        end
        if (dataFire) begin
            reqReg.data <= dataIn;
        end
    end

    assign req.valid   = reqValid;
    assign req.payload = reqReg;

endmodule

//--- source/frontend.sv
/* Path ORAM frontend without recursion or PLB; the tree backend sits outside.
   End of a command is its storeData or returnData transfer. */

`timescale 1ns/1ps

module frontend (
    input  logic                              Clock,
    input  logic                              reset,
    input  logic                              cmdInValid,
    output logic                              cmdInReady,
    input  frontendPkg::cmdT                  cmdIn,
    input  logic [frontendPkg::addrWidth-1:0] progAddrIn,
    input  logic                              dataInValid,
    output logic                              dataInReady,
    input  frontendPkg::dataT                 dataIn,
    output logic                              returnDataValid,
    input  logic                              returnDataReady,
    output frontendPkg::dataT                 returnData,
    output logic                              cmdOutValid,
    input  logic                              cmdOutReady,
    output frontendPkg::cmdT                  cmdOut,
    output logic [frontendPkg::addrWidth-1:0] addrOut,
    output logic [frontendPkg::leafWidth-1:0] oldLeaf,
    output logic [frontendPkg::leafWidth-1:0] newLeaf,
    output logic                              storeDataValid,
    input  logic                              storeDataReady,
    output frontendPkg::taggedT               storeData,
    input  logic                              loadDataValid,
    output logic                              loadDataReady,
    input  frontendPkg::taggedT               loadData,
    output logic                              integrityError
);

    streamIf #(.payloadT(frontendPkg::reqT))  reqLink ();
    streamIf #(.payloadT(frontendPkg::dataT)) storeLink ();
    streamIf #(.payloadT(frontendPkg::dataT)) loadLink ();
    beCmdIf                                   cmdLink ();

    cmdIntake cmdIntake_inst (
        .Clock       (Clock),
        .reset       (reset),
        .cmdInValid  (cmdInValid),
        .cmdInReady  (cmdInReady),
        .cmdIn       (cmdIn),
        .progAddrIn  (progAddrIn),
        .dataInValid (dataInValid),
        .dataInReady (dataInReady),
        .dataIn      (dataIn),
        .req         (reqLink)
    );

    uoramController uoramController_inst (
        .Clock           (Clock),
        .reset           (reset),
        .req             (reqLink),
        .beCmd           (cmdLink),
        .store           (storeLink),
        .load            (loadLink),
        .returnDataValid (returnDataValid),
        .returnDataReady (returnDataReady),
        .returnData      (returnData)
    );

    integrityVerifier integrityVerifier_inst (
        .Clock          (Clock),
        .reset          (reset),
        .feCmd          (cmdLink),
        .feStore        (storeLink),
        .feLoad         (loadLink),
        .cmdOutValid    (cmdOutValid),
        .cmdOutReady    (cmdOutReady),
        .cmdOut         (cmdOut),
        .addrOut        (addrOut),
        .oldLeaf        (oldLeaf),
        .newLeaf        (newLeaf),
        .storeDataValid (storeDataValid),
        .storeDataReady (storeDataReady),
        .storeData      (storeData),
        .loadDataValid  (loadDataValid),
        .loadDataReady  (loadDataReady),
        .loadData       (loadData),
        .integrityError (integrityError)
    );

endmodule

//--- source/frontendIfc.sv
/* Ready-valid links inside the frontend. A transfer needs valid and ready high
   at a rising edge; the source holds valid and payload until then. */

`timescale 1ns/1ps

// Generic data stream, payload type chosen per instance
interface streamIf #(
    parameter type payloadT = logic
);
    logic    valid;
    logic    ready;
    payloadT payload;

    modport source (output valid, output payload, input ready);
    modport sink   (input valid, input payload, output ready);
endinterface

// Frontend to backend access command
interface beCmdIf;
    logic                                 valid;
    logic                                 ready;
    frontendPkg::cmdT                     cmd;
    logic [frontendPkg::addrWidth-1:0]    addr;
    logic [frontendPkg::leafWidth-1:0]    oldLeaf;
    logic [frontendPkg::leafWidth-1:0]    newLeaf;

    modport source (output valid, output cmd, output addr, output oldLeaf,
                    output newLeaf, input ready);
    modport sink   (input valid, input cmd, input addr, input oldLeaf,
                    input newLeaf, output ready);
endinterface

//--- source/frontendPkg.sv
/* Single-beat blocks only: one block is one dataWidth beat.
   The tag rule assumes addrWidth equals tagWidth and a 32-bit block. */

package frontendPkg;

    // ==========================================================
    // Widths
    // ==========================================================
    localparam int addrWidth = 8;
    localparam int leafWidth = 6;
    localparam int dataWidth = 32;
    localparam int tagWidth  = 8;

    // LFSR start value, must not be zero
    localparam logic [leafWidth-1:0] leafSeed = 6'h2d;

    // ==========================================================
    // Command and payload types
    // ==========================================================
    typedef enum logic [1:0] {
        cmdRead       = 2'd0,
        cmdWrite      = 2'd1,
        cmdReadRemove = 2'd2
    } cmdT;

    typedef logic [dataWidth-1:0] dataT;

    // One program request, data is don't-care for reads
    typedef struct packed {
        cmdT                  cmd;
        logic [addrWidth-1:0] addr;
        dataT                 data;
    } reqT;

    // Block as kept in the backend
    typedef struct packed {
        dataT                data;
        logic [tagWidth-1:0] tag;
    } taggedT;

    // Tag is the XOR of the four data bytes and the block address
    function automatic logic [tagWidth-1:0] blockTag(input dataT data,
                                                     input logic [addrWidth-1:0] addr);
        return data[31:24] ^ data[23:16] ^ data[15:8] ^ data[7:0] ^ addr;
    endfunction

endpackage

//--- source/integrityVerifier.sv
/* Zero-latency pass-through. Store tags use the address of the command in
   flight; a bad load tag sets integrityError until reset. */

`timescale 1ns/1ps

module integrityVerifier (
    input  logic                              Clock,
    input  logic                              reset,
    beCmdIf.sink                              feCmd,
    streamIf.sink                             feStore,
    streamIf.source                           feLoad,
    output logic                              cmdOutValid,
    input  logic                              cmdOutReady,
    output frontendPkg::cmdT                  cmdOut,
    output logic [frontendPkg::addrWidth-1:0] addrOut,
    output logic [frontendPkg::leafWidth-1:0] oldLeaf,
    output logic [frontendPkg::leafWidth-1:0] newLeaf,
    output logic                              storeDataValid,
    input  logic                              storeDataReady,
    output frontendPkg::taggedT               storeData,
    input  logic                              loadDataValid,
    output logic                              loadDataReady,
    input  frontendPkg::taggedT               loadData,
    output logic                              integrityError
);

    logic [frontendPkg::addrWidth-1:0] loadAddr;
    logic                              errorFlag;
    logic                              tagBad;

    // ==========================================================
    // Command path
    // ==========================================================
    assign cmdOutValid = feCmd.valid;
    assign feCmd.ready = cmdOutReady;
    assign cmdOut      = feCmd.cmd;
    assign addrOut     = feCmd.addr;
    assign oldLeaf     = feCmd.oldLeaf;
    assign newLeaf     = feCmd.newLeaf;

    // Address of the block the next load belongs to
    always_ff @(posedge Clock) begin
        if (feCmd.valid && cmdOutReady && feCmd.cmd != frontendPkg::cmdWrite) begin
            loadAddr <= feCmd.addr;
        end
    end

    // ==========================================================
    // Store and load paths
    // ==========================================================
    assign storeDataValid = feStore.valid;
    assign feStore.ready  = storeDataReady;
    assign storeData.data = feStore.payload;
    assign storeData.tag  = frontendPkg::blockTag(feStore.payload, feCmd.addr);

    assign feLoad.valid   = loadDataValid;
    assign loadDataReady  = feLoad.ready;
    assign feLoad.payload = loadData.data;

    assign tagBad = loadData.tag != frontendPkg::blockTag(loadData.data, loadAddr);

    // Sticky error flag
    always_ff @(posedge Clock) begin
        if (reset) begin
            errorFlag <= 1'b0;
        end else if (loadDataValid && feLoad.ready && tagBad) begin
            errorFlag <= 1'b1;
        end
    end

    assign integrityError = errorFlag;

endmodule

//--- source/posMap.sv
/* Lookup result appears one cycle after the address; updates land at the next edge.
   Unmapped addresses read back as leaf zero. */

`timescale 1ns/1ps

module posMap (
    input  logic                              Clock,
    input  logic                              reset,
    input  logic [frontendPkg::addrWidth-1:0] lookupAddr,
    output logic [frontendPkg::leafWidth-1:0] lookupLeaf,
    output logic                              lookupValid,
    input  logic                              updateEn,
    input  logic [frontendPkg::addrWidth-1:0] updateAddr,
    input  logic [frontendPkg::leafWidth-1:0] updateLeaf,
    input  logic                              updateValid
);

    localparam int numBlocks = 2 ** frontendPkg::addrWidth;

    logic [frontendPkg::leafWidth-1:0] leafMem [numBlocks];
    logic [numBlocks-1:0]              validVec;
    logic [frontendPkg::leafWidth-1:0] leafRd;
    logic                              validRd;

    // Leaf table
    always_ff @(posedge Clock) begin
        if (updateEn) begin
            leafMem[updateAddr] <= updateLeaf;
        end
        leafRd <= leafMem[lookupAddr];
    end

    // Valid bits, all entries unmapped after reset
    always_ff @(posedge Clock) begin
        if (reset) begin
            validVec <= '0;
            validRd  <= 1'b0;
        end else begin
            if (updateEn) begin
                validVec[updateAddr] <= updateValid;
            end
            validRd <= validVec[lookupAddr];
        end
    end

    assign lookupValid = validRd;
    assign lookupLeaf  = validRd ? leafRd : '0;

endmodule

//--- source/uoramController.sv
/* One command in flight. Backend command goes out two cycles after a request
   is taken; the next request is taken only after store or return completes. */

`timescale 1ns/1ps

module uoramController (
    input  logic              Clock,
    input  logic              reset,
    streamIf.sink             req,
    beCmdIf.source            beCmd,
    streamIf.source           store,
    streamIf.sink             load,
    output logic              returnDataValid,
    input  logic              returnDataReady,
    output frontendPkg::dataT returnData
);

    typedef enum logic [2:0] {
        stateIdle,
        stateLookup,
        stateUpdate,
        stateCmd,
        stateStore,
        stateLoad,
        stateReturn
    } stateT;

    stateT                             state;
    logic [frontendPkg::leafWidth-1:0] lfsr;
    frontendPkg::cmdT                  cmdReg;
    logic [frontendPkg::addrWidth-1:0] addrReg;
    frontendPkg::dataT                 dataReg;
    logic [frontendPkg::leafWidth-1:0] oldLeafReg;
    logic [frontendPkg::leafWidth-1:0] newLeafReg;
    logic [frontendPkg::leafWidth-1:0] lookupLeaf;
    logic                              isRemove;

    assign isRemove = (cmdReg == frontendPkg::cmdReadRemove);

    posMap posMap_inst (
        .Clock       (Clock),
        .reset       (reset),
        .lookupAddr  (addrReg),
        .lookupLeaf  (lookupLeaf),
        .lookupValid (),
        .updateEn    (state == stateUpdate),
        .updateAddr  (addrReg),
        .updateLeaf  (lfsr),
        .updateValid (!isRemove)
    );

    // ==========================================================
    // Access FSM
    // ==========================================================
    always_ff @(posedge Clock) begin
        if (reset) begin
            state <= stateIdle;
            lfsr  <= frontendPkg::leafSeed;
        end else begin
            case (state)
                stateIdle: begin
                    if (req.valid) begin
                        state <= stateLookup;
                        // Taps for a maximal 6-bit sequence, never reaches zero
                        lfsr  <= {lfsr[4:0], lfsr[5] ^ lfsr[4]};
                    end
                end
                stateLookup: state <= stateUpdate;
                stateUpdate: state <= stateCmd;
                stateCmd: begin
                    if (beCmd.ready) begin
                        state <= (cmdReg == frontendPkg::cmdWrite) ? stateStore : stateLoad;
                    end
                end
                stateStore: begin
                    if (store.ready) begin
                        state <= stateIdle;
                    end
                end
                stateLoad: begin
                    if (load.valid) begin
                        state <= stateReturn;
                    end
                end
                stateReturn: begin
                    if (returnDataReady) begin
                        state <= stateIdle;
                    end
                end
                default: state <= stateIdle;
            endcase
        end
    end

    always_ff @(posedge Clock) begin
        if (state == stateIdle && req.valid) begin
            cmdReg  <= req.payload.cmd;
            addrReg <= req.payload.addr;
            dataReg <= req.payload.data;
        end
        if (state == stateUpdate) begin
            // Map gives leaf zero for unmapped addresses
            oldLeafReg <= lookupLeaf;
            newLeafReg <= isRemove ? '0 : lfsr;
        end
        if (load.valid && load.ready) begin
            dataReg <= load.payload;
        end
    end

    assign req.ready = (state == stateIdle);

    assign beCmd.valid   = (state == stateCmd);
    assign beCmd.cmd     = cmdReg;
    assign beCmd.addr    = addrReg;
    assign beCmd.oldLeaf = oldLeafReg;
    assign beCmd.newLeaf = newLeafReg;

    assign store.valid   = (state == stateStore);
    assign store.payload = dataReg;
    assign load.ready    = (state == stateLoad);

    assign returnDataValid = (state == stateReturn);
    assign returnData      = dataReg;

endmodule

//--- tb/frontendTb.sv
/* Commands go in one at a time and each must finish before the next is sent.
   The backend model keeps one tagged 32-bit block per address. */

`timescale 1ns/1ps

module frontendTb;

    typedef logic [frontendPkg::addrWidth-1:0] addrT;
    typedef logic [frontendPkg::leafWidth-1:0] leafT;

    localparam int clkPeriod = 20;
    localparam int numRandom = 40;
    // Tests 1 to 4 and 6 send 12 commands, test 5 the random ones
    localparam int totalCmds = 12 + numRandom;

    logic                Clock = 1'b0;
    logic                reset;
    logic                cmdInValid;
    logic                cmdInReady;
    frontendPkg::cmdT    cmdIn;
    addrT                progAddrIn;
    logic                dataInValid;
    logic                dataInReady;
    frontendPkg::dataT   dataIn;
    logic                returnDataValid;
    logic                returnDataReady;
    frontendPkg::dataT   returnData;
    logic                cmdOutValid;
    logic                cmdOutReady;
    frontendPkg::cmdT    cmdOut;
    addrT                addrOut;
    leafT                oldLeaf;
    leafT                newLeaf;
    logic                storeDataValid;
    logic                storeDataReady;
    frontendPkg::taggedT storeData;
    logic                loadDataValid;
    logic                loadDataReady;
    frontendPkg::taggedT loadData;
    logic                integrityError;

    integer              seed = 87052;
    int                  errors = 0;
    int                  errStart = 0;
    int                  issued = 0;
    int                  done = 0;
    frontendPkg::dataT   shadowData [256];
    leafT                shadowLeaf [256];
    logic [255:0]        shadowValid;
    frontendPkg::taggedT beMem [256];
    addrT                beAddr;
    int                  loadWait = 0;
    frontendPkg::cmdT    expCmdQ [$];
    addrT                expAddrQ [$];
    frontendPkg::dataT   expDataQ [$];

    frontend frontend_inst (.*);

    always #(clkPeriod / 2) Clock = ~Clock;

    // ==========================================================
    // Reference model
    // ==========================================================
    // Initial block contents, every address bit shows up
    function automatic frontendPkg::dataT fillWord(input addrT a);
        return {a, ~a, a ^ 8'h5a, a + 8'h3c};
    endfunction

    function automatic void refModel(input addrT a, output frontendPkg::dataT expData,
                                     output leafT expLeaf);
        expData = shadowData[a];
        expLeaf = shadowValid[a] ? shadowLeaf[a] : '0;
    endfunction

    task automatic flagError(input string msg);
        $display("ERROR at %0d ns: %s", $time, msg);
        errors++;
    endtask

    task automatic checkData(input frontendPkg::dataT got, exp, input string what);
        if (got !== exp)
            flagError($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic checkLeaf(input leafT got, exp, input string what);
        if (got !== exp)
            flagError($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    task automatic checkCmd(input frontendPkg::cmdT got, exp, input string what);
        if (got !== exp)
            flagError($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    task automatic checkAddr(input addrT got, exp, input string what);
        if (got !== exp)
            flagError($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic checkStore(input frontendPkg::taggedT got, exp, input string what);
        if (got !== exp)
            flagError($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic checkFlag(input logic got, exp, input string what);
        if (got !== exp)
            flagError($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    task automatic retireCommand();
        void'(expCmdQ.pop_front());
        void'(expAddrQ.pop_front());
        void'(expDataQ.pop_front());
        done++;
    endtask

    // ==========================================================
    // Compare process, transfers judged at the falling edge
    // ==========================================================
    initial begin : compare
        frontendPkg::dataT expData;
        leafT              expLeaf;
        addrT              a;
        forever begin
            @(negedge Clock);
            // Map is empty again after any reset
            if (reset)
                shadowValid = '0;
            if (cmdOutValid && cmdOutReady) begin
                if (expCmdQ.size() == 0) begin
                    $display("Backend command seen at %0d ns with no command pending", $time);
                    errors++;
                end else begin
                    a = expAddrQ[0];
                    refModel(a, expData, expLeaf);
                    checkCmd(cmdOut, expCmdQ[0], "cmdOut");
                    checkAddr(addrOut, a, "addrOut");
                    checkLeaf(oldLeaf, expLeaf, "oldLeaf");
                    if (expCmdQ[0] == frontendPkg::cmdReadRemove)
                        checkLeaf(newLeaf, '0, "newLeaf of ReadRemove");
                    shadowValid[a] = (expCmdQ[0] != frontendPkg::cmdReadRemove);
                    shadowLeaf[a]  = newLeaf;
                end
            end
            if (storeDataValid && storeDataReady) begin
                a = expAddrQ[0];
                checkStore(storeData,
                           {expDataQ[0], frontendPkg::blockTag(expDataQ[0], a)},
                           "storeData");
                shadowData[a] = expDataQ[0];
                retireCommand();
            end
            if (returnDataValid && returnDataReady) begin
                refModel(expAddrQ[0], expData, expLeaf);
                checkData(returnData, expData, "returnData");
                retireCommand();
            end
        end
    end

    // ==========================================================
    // Backend and return side, random stalls
    // ==========================================================
    initial begin : backendModel
        logic [31:0] r;
        logic        loadTaken;
        cmdOutReady     = 1'b0;
        storeDataReady  = 1'b0;
        returnDataReady = 1'b0;
        loadDataValid   = 1'b0;
        loadData        = '0;
        forever begin
            @(negedge Clock);
            if (cmdOutValid && cmdOutReady) begin
                beAddr = addrOut;
                r      = $random(seed);
                if (cmdOut != frontendPkg::cmdWrite)
                    loadWait = 1 + int'(r[1:0]);
            end
            if (storeDataValid && storeDataReady)
                beMem[addrOut] = storeData;
            loadTaken = loadDataValid && loadDataReady;
            @(posedge Clock);
            #1;
            r               = $random(seed);
            cmdOutReady     = r[0];
            storeDataReady  = r[1];
            returnDataReady = r[2];
            if (loadTaken) begin
                loadDataValid = 1'b0;
            end else if (loadWait > 0) begin
                loadWait--;
                if (loadWait == 0) begin
                    loadDataValid = 1'b1;
                    loadData      = beMem[beAddr];
                end
            end
        end
    end

    // ==========================================================
    // Stimulus
    // ==========================================================
    task automatic applyReset();
        @(posedge Clock);
        #1;
        reset = 1'b1;
        repeat (2) @(posedge Clock);
        #1;
        reset = 1'b0;
    endtask

    task automatic issueCommand(input frontendPkg::cmdT c, input addrT a,
                                input frontendPkg::dataT d);
        @(posedge Clock);
        #1;
        expCmdQ.push_back(c);
        expAddrQ.push_back(a);
        expDataQ.push_back(d);
        issued++;
        cmdIn      = c;
        progAddrIn = a;
        cmdInValid = 1'b1;
        do begin
            @(negedge Clock);
        end while (!cmdInReady);
        @(posedge Clock);
        #1;
        cmdInValid = 1'b0;
        if (c == frontendPkg::cmdWrite) begin
            dataIn      = d;
            dataInValid = 1'b1;
            do begin
                @(negedge Clock);
            end while (!dataInReady);
            @(posedge Clock);
            #1;
            dataInValid = 1'b0;
        end
        // Finished at the store or return transfer
        wait (done == issued);
    endtask

    task automatic reportTest(input string name);
        $display("Test %s finished with %0d errors", name, errors - errStart);
        errStart = errors;
    endtask

    initial begin : stimulus
        frontendPkg::cmdT c;
        addrT             a;
        logic [31:0]      r;
        reset       = 1'b1;
        cmdInValid  = 1'b0;
        cmdIn       = frontendPkg::cmdRead;
        progAddrIn  = '0;
        dataInValid = 1'b0;
        dataIn      = '0;
        for (int i = 0; i < 256; i++) begin
            shadowData[i] = fillWord(i[7:0]);
            beMem[i]      = {shadowData[i], frontendPkg::blockTag(shadowData[i], i[7:0])};
        end
        applyReset();

        issueCommand(frontendPkg::cmdWrite, 8'h11, 32'hcafe_0011);
        issueCommand(frontendPkg::cmdRead, 8'h11, '0);
        reportTest("write then read");

        issueCommand(frontendPkg::cmdRead, 8'h40, '0);
        reportTest("first access after reset");

        issueCommand(frontendPkg::cmdWrite, 8'h33, 32'h5eed_3333);
        issueCommand(frontendPkg::cmdReadRemove, 8'h33, '0);
        issueCommand(frontendPkg::cmdRead, 8'h33, '0);
        reportTest("read-remove");

        issueCommand(frontendPkg::cmdWrite, 8'hff, 32'h0f0f_a5a5);
        issueCommand(frontendPkg::cmdRead, 8'hff, '0);
        issueCommand(frontendPkg::cmdReadRemove, 8'hff, '0);
        reportTest("command fields and tags");

        // Sixteen addresses so that blocks get hit again
        repeat (numRandom) begin
            r = $random(seed);
            c = (r[5:4] == 2'd3) ? frontendPkg::cmdWrite : frontendPkg::cmdT'(r[5:4]);
            a = {4'h8, r[3:0]};
            issueCommand(c, a, $random(seed));
        end
        checkFlag(integrityError, 1'b0, "integrityError after clean traffic");
        reportTest("random traffic");

        issueCommand(frontendPkg::cmdWrite, 8'h22, 32'h1234_5678);
        // Backend store lands at the same falling edge
        @(posedge Clock);
        beMem[8'h22].data[3] = ~beMem[8'h22].data[3];
        shadowData[8'h22][3] = ~shadowData[8'h22][3];
        issueCommand(frontendPkg::cmdRead, 8'h22, '0);
        checkFlag(integrityError, 1'b1, "integrityError after bad load");
        issueCommand(frontendPkg::cmdRead, 8'h23, '0);
        checkFlag(integrityError, 1'b1, "integrityError held");
        applyReset();
        checkFlag(integrityError, 1'b0, "integrityError after reset");
        reportTest("integrity error");

        $display("Done with %0d commands and %0d errors", done, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // 200 cycles allowed per command
    initial begin : watchdog
        #(totalCmds * 200 * clkPeriod);
        $display("Timeout: the run did not finish within %0d cycles", totalCmds * 200);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- tb/frontend_sva.sv
/* Handshake checks bound into integrityVerifier. The payload is checked
   only while valid waits for ready. */

`timescale 1ns/1ps

module frontend_sva (
    input logic                              Clock,
    input logic                              reset,
    input logic                              cmdOutValid,
    input logic                              cmdOutReady,
    input frontendPkg::cmdT                  cmdOut,
    input logic [frontendPkg::addrWidth-1:0] addrOut,
    input logic [frontendPkg::leafWidth-1:0] oldLeaf,
    input logic [frontendPkg::leafWidth-1:0] newLeaf,
    input logic                              storeDataValid,
    input logic                              storeDataReady,
    input frontendPkg::taggedT               storeData,
    input logic                              integrityError
);

    // Backend command held until taken
    cmdHeld: assert property (@(posedge Clock) disable iff (reset)
        cmdOutValid && !cmdOutReady |=>
            cmdOutValid && $stable({cmdOut, addrOut, oldLeaf, newLeaf}))
        else $error("backend command dropped or changed before cmdOutReady");

    storeHeld: assert property (@(posedge Clock) disable iff (reset)
        storeDataValid && !storeDataReady |=> storeDataValid && $stable(storeData))
        else $error("store data dropped or changed before storeDataReady");

    resetClears: assert property (@(posedge Clock)
        reset |=> !cmdOutValid && !storeDataValid && !integrityError)
        else $error("valid outputs or integrityError high after reset");

endmodule

bind integrityVerifier frontend_sva frontend_sva_inst (
    .Clock          (Clock),
    .reset          (reset),
    .cmdOutValid    (cmdOutValid),
    .cmdOutReady    (cmdOutReady),
    .cmdOut         (cmdOut),
    .addrOut        (addrOut),
    .oldLeaf        (oldLeaf),
    .newLeaf        (newLeaf),
    .storeDataValid (storeDataValid),
    .storeDataReady (storeDataReady),
    .storeData      (storeData),
    .integrityError (integrityError)
);
